/* design/soc_bus_defs.svh */
// ----------------------------------------------------------------------
// Region bases and lengths must fit in 32 bits and must not overlap
// ----------------------------------------------------------------------
`ifndef SOC_BUS_DEFS_SVH
`define SOC_BUS_DEFS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_STRB_W 8
`define APB_DATA_W 32

// ----------------------------------------------------------------------
// Region map
// ----------------------------------------------------------------------
`define ROM_BASE    32'h0001_0000
`define ROM_LEN     32'h0001_0000
`define APB_BASE    32'h6000_0000
`define APB_LEN     32'h1000_0000
`define CLINT_BASE  32'h0200_0000
`define CLINT_LEN   32'h000C_0000
`define SLM_BASE    32'h0400_0000
`define SLM_LEN     32'h0400_0000
`define SLMDDR_BASE 32'hC000_0000
`define SLMDDR_LEN  32'h4000_0000
`define DRAM_BASE   32'h8000_0000
`define DRAM_LEN    32'h2000_0000

// Entries in the master-side request FIFO
`define REQ_FIFO_DEPTH 2

`endif

/* design/soc_bus_pkg.sv */
// ----------------------------------------------------------------------
// Single-beat bus types; data is fixed at 64 bits with byte strobes
// ----------------------------------------------------------------------
`default_nettype none

`include "soc_bus_defs.svh"

package soc_bus_pkg;

   // Decoded destination of a request
   typedef enum logic [2:0] {
      TGT_ROM    = 3'd0,
      TGT_APB    = 3'd1,
      TGT_CLINT  = 3'd2,
      TGT_SLM    = 3'd3,
      TGT_SLMDDR = 3'd4,
      TGT_DRAM   = 3'd5,
      TGT_NONE   = 3'd7
   } target_e;

   typedef struct packed {
      logic [`SOC_ADDR_W-1:0] addr;
      logic                   write;
      logic [`SOC_DATA_W-1:0] wdata;
      logic [`SOC_STRB_W-1:0] strb;
   } bus_req_t;

   typedef struct packed {
      logic [`SOC_DATA_W-1:0] rdata;
      logic                   err;
   } bus_rsp_t;

   // Tagged request on the shared memory channel
   typedef struct packed {
      target_e  target;
      bus_req_t req;
   } mem_req_t;

   typedef enum logic [1:0] {
      RT_IDLE = 2'd0,
      RT_MEM  = 2'd1,
      RT_APB  = 2'd2,
      RT_RSP  = 2'd3
   } router_state_e;

   typedef enum logic [1:0] {
      APB_IDLE   = 2'd0,
      APB_SETUP  = 2'd1,
      APB_ACCESS = 2'd2
   } apb_state_e;

endpackage

`default_nettype wire

/* design/req_fifo.sv */
// ----------------------------------------------------------------------
// No bypass path; an entry pushed in one cycle leaves at the earliest
// in the next one
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defs.svh"

module req_fifo #(
   parameter int DEPTH = `REQ_FIFO_DEPTH
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  soc_bus_pkg::bus_req_t in_i,
   input  logic                  in_valid_i,
   output logic                  in_ready_o,
   output soc_bus_pkg::bus_req_t out_o,
   output logic                  out_valid_o,
   input  logic                  out_ready_i
);
   import soc_bus_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   bus_req_t         mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign in_ready_o  = (count_q != CNT_W'(DEPTH));
   assign out_valid_o = (count_q != '0);
   assign out_o       = mem_q[rd_ptr_q];

   assign push = in_valid_i && in_ready_o;
   assign pop  = out_valid_o && out_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= in_i;
      end
   end

endmodule

`default_nettype wire

/* design/addr_decoder.sv */
// ----------------------------------------------------------------------
// Purely combinational; first matching region wins
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defs.svh"

module addr_decoder (
   input  logic [`SOC_ADDR_W-1:0] addr_i,
   output soc_bus_pkg::target_e   target_o
);
   import soc_bus_pkg::*;

   // One extra bit so a region ending at the top of the space still works
   function automatic logic in_region(
      input logic [`SOC_ADDR_W-1:0] addr,
      input logic [`SOC_ADDR_W-1:0] base,
      input logic [`SOC_ADDR_W-1:0] len
   );
      logic [`SOC_ADDR_W:0] limit;
      limit = {1'b0, base} + {1'b0, len};
      return (addr >= base) && ({1'b0, addr} < limit);
   endfunction

   always_comb begin
      if (in_region(addr_i, `ROM_BASE, `ROM_LEN)) begin
         target_o = TGT_ROM;
      end else if (in_region(addr_i, `APB_BASE, `APB_LEN)) begin
         target_o = TGT_APB;
      end else if (in_region(addr_i, `CLINT_BASE, `CLINT_LEN)) begin
         target_o = TGT_CLINT;
      end else if (in_region(addr_i, `SLM_BASE, `SLM_LEN)) begin
         target_o = TGT_SLM;
      end else if (in_region(addr_i, `SLMDDR_BASE, `SLMDDR_LEN)) begin
         target_o = TGT_SLMDDR;
      end else if (in_region(addr_i, `DRAM_BASE, `DRAM_LEN)) begin
         target_o = TGT_DRAM;
      end else begin
         target_o = TGT_NONE;
      end
   end

endmodule

`default_nettype wire

/* design/txn_router.sv */
// ----------------------------------------------------------------------
// One transaction at a time; target_i must be decoded from req_i
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module txn_router (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   // From the request FIFO
   input  soc_bus_pkg::bus_req_t req_i,
   input  logic                  req_valid_i,
   output logic                  req_ready_o,
   input  soc_bus_pkg::target_e  target_i,
   // Memory channel
   output soc_bus_pkg::mem_req_t mem_req_o,
   output logic                  mem_req_valid_o,
   input  logic                  mem_req_ready_i,
   input  soc_bus_pkg::bus_rsp_t mem_rsp_i,
   input  logic                  mem_rsp_valid_i,
   output logic                  mem_rsp_ready_o,
   // APB bridge
   output logic                  apb_start_o,
   output soc_bus_pkg::bus_req_t apb_req_o,
   input  logic                  apb_done_i,
   input  soc_bus_pkg::bus_rsp_t apb_rsp_i,
   // Master response
   output soc_bus_pkg::bus_rsp_t rsp_o,
   output logic                  rsp_valid_o,
   input  logic                  rsp_ready_i
);
   import soc_bus_pkg::*;

   router_state_e state_q;
   logic          mem_valid_q;
   logic          apb_start_q;
   bus_req_t      req_q;
   target_e       target_q;
   bus_rsp_t      rsp_q;
   logic          accept;
   logic          mem_rsp_hs;

   assign req_ready_o = (state_q == RT_IDLE);
   assign accept      = req_valid_i && req_ready_o;

   assign mem_req_o       = '{target: target_q, req: req_q};
   assign mem_req_valid_o = mem_valid_q;
   // Response side opens only once the request has gone out
   assign mem_rsp_ready_o = (state_q == RT_MEM) && !mem_valid_q;
   assign mem_rsp_hs      = mem_rsp_valid_i && mem_rsp_ready_o;

   assign apb_start_o = apb_start_q;
   assign apb_req_o   = req_q;

   assign rsp_o       = rsp_q;
   assign rsp_valid_o = (state_q == RT_RSP);

   // ----------------------------------------------------------------------
   // Control FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= RT_IDLE;
         mem_valid_q <= 1'b0;
         apb_start_q <= 1'b0;
      end else begin
         apb_start_q <= 1'b0;
         case (state_q)
            RT_IDLE: begin
               if (accept) begin
                  case (target_i)
                     TGT_NONE: begin
                        state_q <= RT_RSP;
                     end
                     TGT_APB: begin
                        state_q     <= RT_APB;
                        apb_start_q <= 1'b1;
                     end
                     default: begin
                        state_q     <= RT_MEM;
                        mem_valid_q <= 1'b1;
                     end
                  endcase
               end
            end
            RT_MEM: begin
               if (mem_valid_q && mem_req_ready_i) begin
                  mem_valid_q <= 1'b0;
               end
               if (mem_rsp_hs) begin
                  state_q <= RT_RSP;
               end
            end
            RT_APB: begin
               if (apb_done_i) begin
                  state_q <= RT_RSP;
               end
            end
            RT_RSP: begin
               if (rsp_ready_i) begin
                  state_q <= RT_IDLE;
               end
            end
            default: state_q <= RT_IDLE;
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q    <= req_i;
         target_q <= target_i;
      end
      if (accept && target_i == TGT_NONE) begin
         rsp_q.rdata <= '0;
         rsp_q.err   <= 1'b1;
      end else if (mem_rsp_hs) begin
         rsp_q <= mem_rsp_i;
      end else if (state_q == RT_APB && apb_done_i) begin
         rsp_q <= apb_rsp_i;
      end
   end

endmodule

`default_nettype wire

/* design/apb_bridge.sv */
// ----------------------------------------------------------------------
// One APB3 transfer per start; strobes are not carried, write rdata is 0
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defs.svh"

module apb_bridge (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   start_i,
   input  soc_bus_pkg::bus_req_t  req_i,
   output logic                   done_o,
   output soc_bus_pkg::bus_rsp_t  rsp_o,
   // APB master side
   output logic [`SOC_ADDR_W-1:0] paddr_o,
   output logic                   pwrite_o,
   output logic [`APB_DATA_W-1:0] pwdata_o,
   output logic                   psel_o,
   output logic                   penable_o,
   input  logic [`APB_DATA_W-1:0] prdata_i,
   input  logic                   pready_i,
   input  logic                   pslverr_i
);
   import soc_bus_pkg::*;

   apb_state_e             state_q;
   logic                   done_q;
   logic [`SOC_ADDR_W-1:0] paddr_q;
   logic                   pwrite_q;
   logic [`APB_DATA_W-1:0] pwdata_q;
   bus_rsp_t               rsp_q;
   logic                   launch;
   logic                   finish;

   assign launch = (state_q == APB_IDLE) && start_i;
   assign finish = (state_q == APB_ACCESS) && pready_i;

   assign psel_o    = (state_q != APB_IDLE);
   assign penable_o = (state_q == APB_ACCESS);
   assign paddr_o   = paddr_q;
   assign pwrite_o  = pwrite_q;
   assign pwdata_o  = pwdata_q;
   assign done_o    = done_q;
   assign rsp_o     = rsp_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= APB_IDLE;
         done_q  <= 1'b0;
      end else begin
         done_q <= finish;
         case (state_q)
            APB_IDLE: begin
               if (start_i) begin
                  state_q <= APB_SETUP;
               end
            end
            APB_SETUP:  state_q <= APB_ACCESS;
            APB_ACCESS: begin
               if (pready_i) begin
                  state_q <= APB_IDLE;
               end
            end
            default: state_q <= APB_IDLE;
         endcase
      end
   end

   // Address bit 2 selects the 32-bit lane of the 64-bit bus
   always_ff @(posedge clk_i) begin
      if (launch) begin
         paddr_q  <= req_i.addr;
         pwrite_q <= req_i.write;
         pwdata_q <= req_i.addr[2] ? req_i.wdata[`SOC_DATA_W-1:`APB_DATA_W]
                                   : req_i.wdata[`APB_DATA_W-1:0];
      end
      if (finish) begin
         rsp_q.err <= pslverr_i;
         if (pwrite_q) begin
            rsp_q.rdata <= '0;
         end else if (paddr_q[2]) begin
            rsp_q.rdata <= {prdata_i, {`APB_DATA_W{1'b0}}};
         end else begin
            rsp_q.rdata <= {{`APB_DATA_W{1'b0}}, prdata_i};
         end
      end
   end

endmodule

`default_nettype wire

/* design/soc_bus_top.sv */
// ----------------------------------------------------------------------
// Single master; responses return in request order
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defs.svh"

module soc_bus_top (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   // Master request and response
   input  soc_bus_pkg::bus_req_t  req_i,
   input  logic                   req_valid_i,
   output logic                   req_ready_o,
   output soc_bus_pkg::bus_rsp_t  rsp_o,
   output logic                   rsp_valid_o,
   input  logic                   rsp_ready_i,
   // Memory channel
   output soc_bus_pkg::mem_req_t  mem_req_o,
   output logic                   mem_req_valid_o,
   input  logic                   mem_req_ready_i,
   input  soc_bus_pkg::bus_rsp_t  mem_rsp_i,
   input  logic                   mem_rsp_valid_i,
   output logic                   mem_rsp_ready_o,
   // APB
   output logic [`SOC_ADDR_W-1:0] paddr_o,
   output logic                   pwrite_o,
   output logic [`APB_DATA_W-1:0] pwdata_o,
   output logic                   psel_o,
   output logic                   penable_o,
   input  logic [`APB_DATA_W-1:0] prdata_i,
   input  logic                   pready_i,
   input  logic                   pslverr_i
);
   import soc_bus_pkg::*;

   bus_req_t fifo_req;
   logic     fifo_valid;
   logic     fifo_ready;
   target_e  target;
   logic     apb_start;
   bus_req_t apb_req;
   logic     apb_done;
   bus_rsp_t apb_rsp;

   // ----------------------------------------------------------------------
   // Input side
   // ----------------------------------------------------------------------
   req_fifo #(
      .DEPTH (`REQ_FIFO_DEPTH)
   ) u_req_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_i        (req_i),
      .in_valid_i  (req_valid_i),
      .in_ready_o  (req_ready_o),
      .out_o       (fifo_req),
      .out_valid_o (fifo_valid),
      .out_ready_i (fifo_ready)
   );

   // ----------------------------------------------------------------------
   // Decode and routing
   // ----------------------------------------------------------------------
   addr_decoder u_addr_decoder (
      .addr_i   (fifo_req.addr),
      .target_o (target)
   );

   txn_router u_txn_router (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .req_i           (fifo_req),
      .req_valid_i     (fifo_valid),
      .req_ready_o     (fifo_ready),
      .target_i        (target),
      .mem_req_o       (mem_req_o),
      .mem_req_valid_o (mem_req_valid_o),
      .mem_req_ready_i (mem_req_ready_i),
      .mem_rsp_i       (mem_rsp_i),
      .mem_rsp_valid_i (mem_rsp_valid_i),
      .mem_rsp_ready_o (mem_rsp_ready_o),
      .apb_start_o     (apb_start),
      .apb_req_o       (apb_req),
      .apb_done_i      (apb_done),
      .apb_rsp_i       (apb_rsp),
      .rsp_o           (rsp_o),
      .rsp_valid_o     (rsp_valid_o),
      .rsp_ready_i     (rsp_ready_i)
   );

   // Peripheral side
   apb_bridge u_apb_bridge (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .start_i   (apb_start),
      .req_i     (apb_req),
      .done_o    (apb_done),
      .rsp_o     (apb_rsp),
      .paddr_o   (paddr_o),
      .pwrite_o  (pwrite_o),
      .pwdata_o  (pwdata_o),
      .psel_o    (psel_o),
      .penable_o (penable_o),
      .prdata_i  (prdata_i),
      .pready_i  (pready_i),
      .pslverr_i (pslverr_i)
   );

endmodule

`default_nettype wire

/* tb/soc_bus_checker.sv */
// ----------------------------------------------------------------------
// Port-level protocol assertions, inactive while reset is low
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module soc_bus_checker (
   input logic                  clk_i,
   input logic                  rst_n_i,
   input soc_bus_pkg::bus_rsp_t rsp_i,
   input logic                  rsp_valid_i,
   input logic                  rsp_ready_i,
   input soc_bus_pkg::mem_req_t mem_req_i,
   input logic                  mem_req_valid_i,
   input logic                  mem_req_ready_i,
   input logic                  psel_i,
   input logic                  penable_i
);

   penable_needs_psel: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) penable_i |-> psel_i
   ) else $error("penable high without psel");

   // APB setup lasts exactly one cycle
   setup_then_access: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) (psel_i && !penable_i) |=> (psel_i && penable_i)
   ) else $error("APB setup phase not followed by access phase");

   rsp_held: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i))
   ) else $error("response changed while stalled");

   mem_req_held: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (mem_req_valid_i && !mem_req_ready_i) |=> (mem_req_valid_i && $stable(mem_req_i))
   ) else $error("memory request changed while stalled");

   one_path_only: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !(mem_req_valid_i && psel_i)
   ) else $error("memory channel and APB active together");

endmodule

`default_nettype wire

/* tb/soc_bus_tb.sv */
// ----------------------------------------------------------------------
// Random traffic against memory and APB responders; needs timing and
// assertion support in the simulator
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defs.svh"

module soc_bus_tb;
   import soc_bus_pkg::*;

   localparam int NUM_REQ      = 400;
   localparam int RESET_CYCLES = 10;
   localparam int MAX_CYCLES   = NUM_REQ * 40 + RESET_CYCLES;

   localparam logic [31:0] REGION_BASE [6] = '{`ROM_BASE, `APB_BASE, `CLINT_BASE,
                                               `SLM_BASE, `SLMDDR_BASE, `DRAM_BASE};
   localparam logic [31:0] REGION_LEN [6]  = '{`ROM_LEN, `APB_LEN, `CLINT_LEN,
                                               `SLM_LEN, `SLMDDR_LEN, `DRAM_LEN};

   logic                   clk_i;
   logic                   rst_n_i;
   bus_req_t               req_i;
   logic                   req_valid_i;
   logic                   req_ready_o;
   bus_rsp_t               rsp_o;
   logic                   rsp_valid_o;
   logic                   rsp_ready_i;
   mem_req_t               mem_req_o;
   logic                   mem_req_valid_o;
   logic                   mem_req_ready_i;
   bus_rsp_t               mem_rsp_i;
   logic                   mem_rsp_valid_i;
   logic                   mem_rsp_ready_o;
   logic [`SOC_ADDR_W-1:0] paddr_o;
   logic                   pwrite_o;
   logic [`APB_DATA_W-1:0] pwdata_o;
   logic                   psel_o;
   logic                   penable_o;
   logic [`APB_DATA_W-1:0] prdata_i;
   logic                   pready_i;
   logic                   pslverr_i;

   bus_req_t    stim [NUM_REQ];
   bus_rsp_t    exp_rsp_q [$];
   mem_req_t    exp_mem_q [$];
   bus_req_t    exp_apb_q [$];
   mem_req_t    mem_pend_q [$];
   logic [31:0] model_regs [256];
   logic [31:0] slave_regs [256];
   int          errors;
   int          checks;
   int          req_sent;
   int          rsp_count;
   int          cycles;
   int          apb_wait;
   logic        running;
   logic        saw_full;
   logic        req_xfer;
   logic        mem_rsp_xfer;

   soc_bus_top uut (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .req_i           (req_i),
      .req_valid_i     (req_valid_i),
      .req_ready_o     (req_ready_o),
      .rsp_o           (rsp_o),
      .rsp_valid_o     (rsp_valid_o),
      .rsp_ready_i     (rsp_ready_i),
      .mem_req_o       (mem_req_o),
      .mem_req_valid_o (mem_req_valid_o),
      .mem_req_ready_i (mem_req_ready_i),
      .mem_rsp_i       (mem_rsp_i),
      .mem_rsp_valid_i (mem_rsp_valid_i),
      .mem_rsp_ready_o (mem_rsp_ready_o),
      .paddr_o         (paddr_o),
      .pwrite_o        (pwrite_o),
      .pwdata_o        (pwdata_o),
      .psel_o          (psel_o),
      .penable_o       (penable_o),
      .prdata_i        (prdata_i),
      .pready_i        (pready_i),
      .pslverr_i       (pslverr_i)
   );

   bind soc_bus_top soc_bus_checker u_checker (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .rsp_i           (rsp_o),
      .rsp_valid_i     (rsp_valid_o),
      .rsp_ready_i     (rsp_ready_i),
      .mem_req_i       (mem_req_o),
      .mem_req_valid_i (mem_req_valid_o),
      .mem_req_ready_i (mem_req_ready_i),
      .psel_i          (psel_o),
      .penable_i       (penable_o)
   );

   always #10 clk_i = ~clk_i;

   // ----------------------------------------------------------------------
   // Reference rules
   // ----------------------------------------------------------------------
   // Region index matches the target encoding
   function automatic target_e region_of(input logic [31:0] addr);
      for (int r = 0; r < 6; r++) begin
         if ((addr - REGION_BASE[r]) < REGION_LEN[r]) begin
            return target_e'(r);
         end
      end
      return TGT_NONE;
   endfunction

   function automatic logic [63:0] mem_data(input logic [31:0] addr);
      return {addr * 32'h9E37_79B1, addr ^ 32'h5BD1_E995};
   endfunction

   function automatic logic mem_err(input logic [31:0] addr);
      return addr[6:4] == 3'b101;
   endfunction

   function automatic logic apb_err(input logic [31:0] addr);
      return addr[6:3] == 4'hF;
   endfunction

   function automatic logic [31:0] wr_lane(input bus_req_t req);
      return req.addr[2] ? req.wdata[63:32] : req.wdata[31:0];
   endfunction

   function automatic logic chance(input int unsigned pct);
      return ($urandom % 100) < pct;
   endfunction

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("ERROR: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         errors++;
         $display("%s", what);
      end
   endtask

   task automatic make_stimulus();
      logic [31:0] addr;
      logic [31:0] rnd;
      int unsigned r;
      for (int i = 0; i < NUM_REQ; i++) begin
         r = $urandom % 7;
         if (r == 6) begin
            // Unmapped gaps
            do begin
               addr = $urandom;
            end while (region_of(addr) != TGT_NONE);
         end else if (target_e'(r) == TGT_APB) begin
            // Small window so reads hit earlier writes
            addr = `APB_BASE + ($urandom & 32'h7F);
         end else begin
            addr = REGION_BASE[r] + ($urandom % REGION_LEN[r]);
         end
         rnd = $urandom;
         stim[i].addr  = addr;
         stim[i].write = rnd[0];
         stim[i].wdata = {$urandom, $urandom};
         stim[i].strb  = rnd[15:8];
      end
   endtask

   task automatic predict(input bus_req_t req);
      target_e    tgt;
      bus_rsp_t   rsp;
      mem_req_t   mreq;
      logic [7:0] idx;
      tgt = region_of(req.addr);
      idx = req.addr[9:2];
      case (tgt)
         TGT_NONE: begin
            rsp.rdata = '0;
            rsp.err   = 1'b1;
         end
         TGT_APB: begin
            exp_apb_q.push_back(req);
            rsp.err = apb_err(req.addr);
            if (req.write) begin
               rsp.rdata       = '0;
               model_regs[idx] = wr_lane(req);
            end else begin
               rsp.rdata = req.addr[2] ? {model_regs[idx], 32'h0} : {32'h0, model_regs[idx]};
            end
         end
         default: begin
            mreq.target = tgt;
            mreq.req    = req;
            exp_mem_q.push_back(mreq);
            rsp.rdata = mem_data(req.addr);
            rsp.err   = mem_err(req.addr);
         end
      endcase
      exp_rsp_q.push_back(rsp);
   endtask

   // ----------------------------------------------------------------------
   // Falling-edge driver; handshakes found here complete on the next rise
   // ----------------------------------------------------------------------
   task automatic retire_transfers();
      if (req_xfer) begin
         req_valid_i = 1'b0;
         req_sent++;
      end
      if (mem_rsp_xfer) begin
         mem_rsp_valid_i = 1'b0;
         void'(mem_pend_q.pop_front());
      end
   endtask

   task automatic drive_inputs();
      logic [7:0] idx;
      if (!req_valid_i && req_sent < NUM_REQ && chance(70)) begin
         req_i       = stim[req_sent];
         req_valid_i = 1'b1;
      end
      rsp_ready_i     = chance(60);
      mem_req_ready_i = chance(60);
      if (!mem_rsp_valid_i && mem_pend_q.size() != 0 && chance(50)) begin
         mem_rsp_i.rdata = mem_data(mem_pend_q[0].req.addr);
         mem_rsp_i.err   = mem_err(mem_pend_q[0].req.addr);
         mem_rsp_valid_i = 1'b1;
      end
      // APB slave with random wait states
      pready_i = 1'b0;
      if (psel_o && penable_o) begin
         if (apb_wait > 0) begin
            apb_wait--;
         end else begin
            idx       = paddr_o[9:2];
            pready_i  = 1'b1;
            prdata_i  = slave_regs[idx];
            pslverr_i = apb_err(paddr_o);
         end
      end
   endtask

   task automatic capture_transfers();
      bus_rsp_t exp_rsp;
      mem_req_t exp_mem;
      bus_req_t exp_apb;
      int       outstanding;
      outstanding  = req_sent - rsp_count;
      req_xfer     = req_valid_i && req_ready_o;
      mem_rsp_xfer = mem_rsp_valid_i && mem_rsp_ready_o;
      // FIFO holds the outstanding requests minus the one in the router
      if (!req_ready_o) begin
         saw_full = 1'b1;
         check_true(outstanding >= `REQ_FIFO_DEPTH,
                    "req_ready_o low before the request FIFO filled");
      end else begin
         check_true(outstanding <= `REQ_FIFO_DEPTH,
                    "req_ready_o high with the request FIFO full");
      end
      if (req_xfer) begin
         predict(req_i);
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
         check_true(exp_mem_q.size() != 0, "Memory request issued with none expected");
         if (exp_mem_q.size() != 0) begin
            exp_mem = exp_mem_q.pop_front();
            check_value("mem_req_o", 128'(mem_req_o), 128'(exp_mem));
         end
         mem_pend_q.push_back(mem_req_o);
      end
      if (psel_o && !penable_o) begin
         apb_wait = int'($urandom % 4);
         check_true(exp_apb_q.size() != 0, "APB setup phase with no APB request expected");
         if (exp_apb_q.size() != 0) begin
            exp_apb = exp_apb_q.pop_front();
            check_value("paddr_o", 128'(paddr_o), 128'(exp_apb.addr));
            check_value("pwrite_o", 128'(pwrite_o), 128'(exp_apb.write));
            if (exp_apb.write) begin
               check_value("pwdata_o", 128'(pwdata_o), 128'(wr_lane(exp_apb)));
            end
         end
      end
      if (psel_o && penable_o && pready_i && pwrite_o) begin
         slave_regs[paddr_o[9:2]] = pwdata_o;
      end
      if (rsp_valid_o && rsp_ready_i) begin
         check_true(exp_rsp_q.size() != 0, "Response returned with no request outstanding");
         if (exp_rsp_q.size() != 0) begin
            exp_rsp = exp_rsp_q.pop_front();
            check_value("rsp_o", 128'(rsp_o), 128'(exp_rsp));
         end
         rsp_count++;
      end
   endtask

   always @(negedge clk_i) begin
      if (running) begin
         retire_transfers();
         drive_inputs();
         capture_transfers();
      end
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("Timeout after %0d cycles: %0d of %0d responses, %0d errors",
                  cycles, rsp_count, NUM_REQ, errors);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'h5126abbc));
      clk_i           = 1'b0;
      rst_n_i         = 1'b0;
      req_i           = '0;
      req_valid_i     = 1'b0;
      rsp_ready_i     = 1'b0;
      mem_req_ready_i = 1'b0;
      mem_rsp_i       = '0;
      mem_rsp_valid_i = 1'b0;
      prdata_i        = '0;
      pready_i        = 1'b0;
      pslverr_i       = 1'b0;
      errors          = 0;
      checks          = 0;
      req_sent        = 0;
      rsp_count       = 0;
      cycles          = 0;
      apb_wait        = 0;
      running         = 1'b0;
      saw_full        = 1'b0;
      req_xfer        = 1'b0;
      mem_rsp_xfer    = 1'b0;
      for (int i = 0; i < 256; i++) begin
         slave_regs[i] = (32'(i) * 32'h0101_0101) ^ 32'hC3A5_0F00;
         model_regs[i] = slave_regs[i];
      end
      make_stimulus();

      repeat (RESET_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      check_value("rsp_valid_o", 128'(rsp_valid_o), 128'(0));
      check_value("mem_req_valid_o", 128'(mem_req_valid_o), 128'(0));
      check_value("mem_rsp_ready_o", 128'(mem_rsp_ready_o), 128'(0));
      check_value("psel_o", 128'(psel_o), 128'(0));
      check_value("penable_o", 128'(penable_o), 128'(0));
      check_value("req_ready_o", 128'(req_ready_o), 128'(1));
      rst_n_i = 1'b1;
      @(posedge clk_i);
      running = 1'b1;

      while (rsp_count < NUM_REQ) begin
         @(posedge clk_i);
      end
      repeat (10) @(posedge clk_i);
      check_true(exp_rsp_q.size() == 0 && exp_mem_q.size() == 0 && exp_apb_q.size() == 0,
                 "Expected transfers left over at the end of the run");
      check_true(saw_full, "req_ready_o never fell with requests queued");
      $display("Checks: %0d, errors: %0d, responses: %0d", checks, errors, rsp_count);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/soc_bus_pkg.sv
design/req_fifo.sv
design/addr_decoder.sv
design/txn_router.sv
design/apb_bridge.sv
design/soc_bus_top.sv
tb/soc_bus_checker.sv
tb/soc_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module soc_bus_tb -f verilog.f

output=$(./obj_dir/Vsoc_bus_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
   exit 0
fi
exit 1
